//--- Makefile
# Verilator build and run for the MIPS decode and execute slice

VERILATOR ?= verilator
TOP ?= mipsCoreTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= sim passed

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Run from the project root so the test data file is found
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- aluExecute.sv
`default_nettype none

module aluExecute
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input exStageT inStage,
	output wbStageT outStage,
	output wbStageT bypassEx,
	output logic [dataW-1:0] hi,
	output logic [dataW-1:0] lo
);

	exStageT exReg;
	wbStageT exResult;
	logic [dataW-1:0] immExt;
	logic [dataW-1:0] opB;
	logic [4:0] shAmt;
	logic [dataW-1:0] aluRes;
	logic signed [2*dataW-1:0] mulA;
	logic signed [2*dataW-1:0] mulB;
	logic signed [2*dataW-1:0] product;

	//////////////////////////////////////////////////
	// Execute register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exReg <= '0;
		end else if (inStage.valid) begin
			exReg <= inStage;
		end else begin
			// Bubble keeps the old payload
			exReg.valid <= 1'b0;
		end
	end

	// Operand B and shift amount
	assign immExt = exReg.ctrl.signExt ? {{16{exReg.imm[15]}}, exReg.imm} : {16'h0, exReg.imm};
	assign opB = exReg.ctrl.aluSrcImm ? immExt : exReg.rtVal;
	assign shAmt = exReg.ctrl.shiftByShamt ? exReg.shamt : exReg.rsVal[4:0];

	//////////////////////////////////////////////////
	// ALU and shifter
	//////////////////////////////////////////////////

	always_comb begin
		case (exReg.ctrl.aluOp)
			aluAdd: aluRes = exReg.rsVal + opB;
			aluSub: aluRes = exReg.rsVal - opB;
			aluAnd: aluRes = exReg.rsVal & opB;
			aluOr: aluRes = exReg.rsVal | opB;
			aluXor: aluRes = exReg.rsVal ^ opB;
			aluNor: aluRes = ~(exReg.rsVal | opB);
			aluSlt: aluRes = {31'b0, $signed(exReg.rsVal) < $signed(opB)};
			aluSltu: aluRes = {31'b0, exReg.rsVal < opB};
			// Shifts always act on rt
			aluSll: aluRes = exReg.rtVal << shAmt;
			aluSrl: aluRes = exReg.rtVal >> shAmt;
			aluSra: aluRes = $signed(exReg.rtVal) >>> shAmt;
			aluLui: aluRes = {exReg.imm, 16'h0};
			default: aluRes = '0;
		endcase
	end

	// Operands widened to the full product width
	// Fill bit is the sign only for mult
	assign mulA = {{dataW{exReg.ctrl.mulSigned & exReg.rsVal[dataW-1]}}, exReg.rsVal};
	assign mulB = {{dataW{exReg.ctrl.mulSigned & exReg.rtVal[dataW-1]}}, exReg.rtVal};
	assign product = mulA * mulB;

	//////////////////////////////////////////////////
	// HI/LO registers updated at end of execute
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
		end else if (exReg.valid && exReg.ctrl.hiloWrite) begin
			if (exReg.ctrl.isMul) begin
				hi <= product[2*dataW-1:dataW];
				lo <= product[dataW-1:0];
			end else if (exReg.ctrl.hiSel) begin
				hi <= exReg.rsVal;
			end else begin
				lo <= exReg.rsVal;
			end
		end
	end

	// Result bundle for the next stage and for bypass
	always_comb begin
		exResult.valid = exReg.valid;
		exResult.exc = exReg.exc;
		// r0 writes already dropped in decode
		exResult.regWrite = exReg.valid && exReg.ctrl.regWrite;
		exResult.dest = exReg.dest;
		if (exReg.ctrl.hiloToReg) begin
			exResult.data = exReg.ctrl.hiSel ? hi : lo;
		end else begin
			exResult.data = aluRes;
		end
	end

	assign outStage = exResult;
	assign bypassEx = exResult;

	// Trapped instruction must not reach any state
	excNoWrite: assert property (@(posedge clk) disable iff (!rstN)
		exReg.valid && (exReg.exc != excNone) |-> !exReg.ctrl.regWrite && !exReg.ctrl.hiloWrite);

	// Reported writes never target r0
	destNonZero: assert property (@(posedge clk) disable iff (!rstN)
		outStage.regWrite |-> outStage.dest != zeroReg);

endmodule

`default_nettype wire

//--- coreTests.mem
// instr exc we dest data ; exc 0 none, 1 break, 2 syscall, 3 reserved
// dest and data are checked when we is 1; mthi/mtlo rows hold the expected HI/LO in data
// Immediates: lui, ori, addiu, andi, xori, slti, sltiu
3C011234 0 1 01 12340000
34215678 0 1 01 12345678
2402FFFF 0 1 02 FFFFFFFF
3023FF0F 0 1 03 00005608
38448001 0 1 04 FFFF7FFE
28450001 0 1 05 00000001
2C268000 0 1 06 00000001
// R-type ALU: addu, subu, nor, xor, or, slt, sltu, sub
00223821 0 1 07 12345677
00614023 0 1 08 EDCBFF90
00234827 0 1 09 EDCBA987
00815026 0 1 0A EDCB2986
00655825 0 1 0B 00005609
0002602A 0 1 0C 00000000
0002682B 0 1 0D 00000001
00069822 0 1 13 FFFFFFFF
// Shifts: sll, sra, srlv, srav, srl
00017100 0 1 0E 23456780
00047A03 0 1 0F FFFFFF7F
00648006 0 1 10 00FFFF7F
00C88807 0 1 11 F6E5FFC8
00089702 0 1 12 0000000E
// Dependent chain on r20
24140005 0 1 14 00000005
0294A021 0 1 14 0000000A
0294A021 0 1 14 00000014
0286A823 0 1 15 00000013
// mult, mfhi, mflo, multu, mfhi
00540018 0 0 00 00000000
0000B010 0 1 16 FFFFFFFF
0000B812 0 1 17 FFFFFFEC
00540019 0 0 00 00000000
0000B010 0 1 16 00000013
// mthi r1, mtlo r8, read back
00200011 0 0 00 12345678
01000013 0 0 00 EDCBFF90
0000C012 0 1 18 EDCBFF90
0000C810 0 1 19 12345678
// break, syscall, lw, bad funct, then r1 unchanged
0000000D 1 0 00 00000000
0000000C 2 0 00 00000000
8C010000 3 0 00 00000000
00000801 3 0 00 00000000
0020D025 0 1 1A 12345678
// Write to r0 dropped, r0 still reads 0
24001234 0 0 00 00000000
0000D821 0 1 1B 00000000
// End of list
FFFFFFFF 0 0 00 00000000

//--- mainDecoder.sv
`default_nettype none

module mainDecoder
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;
(
	input instrWordT instr,
	output ctrlT ctrl,
	output excT exc
);

	logic [5:0] op;
	logic [5:0] funct;

	// Opcode shared by both views
	assign op = instr.iFields.op;
	// Function code only meaningful for R-type
	assign funct = instr.rFields.funct;

	//////////////////////////////////////////////////
	// Control generation
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		exc = excNone;
		case (op)
			rType: begin
				// Most R-type ops write rd
				ctrl.regDstRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					addFn, adduFn: ctrl.aluOp = aluAdd;
					subFn, subuFn: ctrl.aluOp = aluSub;
					andFn: ctrl.aluOp = aluAnd;
					orFn: ctrl.aluOp = aluOr;
					xorFn: ctrl.aluOp = aluXor;
					norFn: ctrl.aluOp = aluNor;
					sltFn: ctrl.aluOp = aluSlt;
					sltuFn: ctrl.aluOp = aluSltu;
					// Shift amount from shamt field
					sllFn, srlFn, sraFn: begin
						ctrl.shiftByShamt = 1'b1;
						ctrl.aluOp = (funct == sllFn) ? aluSll :
							(funct == srlFn) ? aluSrl : aluSra;
					end
					// Shift amount from rs
					sllvFn: ctrl.aluOp = aluSll;
					srlvFn: ctrl.aluOp = aluSrl;
					sravFn: ctrl.aluOp = aluSra;
					mfhiFn, mfloFn: begin
						ctrl.hiloToReg = 1'b1;
						ctrl.hiSel = ~funct[1];
					end
					// Move into HI or LO without a GPR write
					mthiFn, mtloFn: begin
						ctrl.regWrite = 1'b0;
						ctrl.hiloWrite = 1'b1;
						ctrl.hiSel = ~funct[1];
					end
					multFn, multuFn: begin
						ctrl.regWrite = 1'b0;
						ctrl.hiloWrite = 1'b1;
						ctrl.isMul = 1'b1;
						ctrl.mulSigned = ~funct[0];
					end
					breakFn: begin
						ctrl = '0;
						exc = excBrk;
					end
					syscallFn: begin
						ctrl = '0;
						exc = excSys;
					end
					default: begin
						ctrl = '0;
						exc = excResv;
					end
				endcase
			end
			// Arithmetic immediates write rt
			addiuOp, sltiOp, sltiuOp: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = (op == addiuOp) ? aluAdd :
					(op == sltiOp) ? aluSlt : aluSltu;
			end
			andiOp, oriOp, xoriOp, luiOp: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = (op == andiOp) ? aluAnd :
					(op == oriOp) ? aluOr :
					(op == xoriOp) ? aluXor : aluLui;
			end
			// Loads, stores, branches and CP0 all land here
			default: exc = excResv;
		endcase
		// Hardwired r0 never takes a write
		if ((ctrl.regDstRd ? instr.rFields.rd : instr.iFields.rt) == zeroReg) begin
			ctrl.regWrite = 1'b0;
		end
	end

	// Register file and HI/LO writes are exclusive
	always_comb begin
		assert (!(ctrl.regWrite && ctrl.hiloWrite))
			else $error("decoder drives regWrite and hiloWrite together");
	end

endmodule

`default_nettype wire

//--- mipsCore.sv
`default_nettype none

module mipsCore
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input instrWordT instr,
	output logic retire,
	output excT retireExc,
	output logic retireWe,
	output logic [regAddrW-1:0] retireDest,
	output logic [dataW-1:0] retireData,
	output logic [dataW-1:0] hiOut,
	output logic [dataW-1:0] loOut
);

	ctrlT decCtrl;
	excT decExc;
	exStageT exIn;
	wbStageT exOut;
	wbStageT exBypass;
	logic [dataW-1:0] rsVal;
	logic [dataW-1:0] rtVal;

	mainDecoder u_mainDecoder (
		.instr(instr),
		.ctrl(decCtrl),
		.exc(decExc)
	);

	//////////////////////////////////////////////////
	// Decode to execute bundle
	//////////////////////////////////////////////////

	assign exIn.valid = instrValid;
	assign exIn.ctrl = decCtrl;
	assign exIn.exc = decExc;
	// rd for R-type, rt for immediates
	assign exIn.dest = decCtrl.regDstRd ? instr.rFields.rd : instr.iFields.rt;
	assign exIn.rsVal = rsVal;
	assign exIn.rtVal = rtVal;
	assign exIn.imm = instr.iFields.imm;
	assign exIn.shamt = instr.rFields.shamt;

	aluExecute u_aluExecute (
		.clk(clk),
		.rstN(rstN),
		.inStage(exIn),
		.outStage(exOut),
		.bypassEx(exBypass),
		.hi(hiOut),
		.lo(loOut)
	);

	regFileWriteback u_regFileWriteback (
		.clk(clk),
		.rstN(rstN),
		.inStage(exOut),
		.bypassEx(exBypass),
		.rsAddr(instr.rFields.rs),
		.rtAddr(instr.rFields.rt),
		.rsData(rsVal),
		.rtData(rtVal),
		.retire(retire),
		.retireExc(retireExc),
		.retireWe(retireWe),
		.retireDest(retireDest),
		.retireData(retireData)
	);

endmodule

`default_nettype wire

//--- mipsCoreTb.sv
`default_nettype none

module mipsCoreTb
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;
();

	localparam int clkPeriod = 4;
	localparam int maxTests = 64;
	localparam int wordsPerTest = 5;
	// Instruction word that ends the test list
	localparam logic [dataW-1:0] endMarker = 32'hFFFF_FFFF;

	// One expected retire record
	typedef struct packed {
		logic [31:0] testIdx;
		instrWordT instr;
		excT exc;
		logic we;
		logic [regAddrW-1:0] dest;
		logic [dataW-1:0] data;
	} expRecT;

	logic clk;
	logic rstN;
	logic instrValid;
	instrWordT instr;
	logic retire;
	excT retireExc;
	logic retireWe;
	logic [regAddrW-1:0] retireDest;
	logic [dataW-1:0] retireData;
	logic [dataW-1:0] hiOut;
	logic [dataW-1:0] loOut;

	logic [dataW-1:0] testMem [maxTests*wordsPerTest];
	expRecT expQ [$];
	int testCount;
	int passCount;
	int failCount;
	int strayCount;
	integer seed;
	logic loaded;

	tbClock u_tbClock (
		.clk(clk),
		.rstN(rstN)
	);

	mipsCore u_mipsCore (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.retire(retire),
		.retireExc(retireExc),
		.retireWe(retireWe),
		.retireDest(retireDest),
		.retireData(retireData),
		.hiOut(hiOut),
		.loOut(loOut)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Five words per test, see data file header
	function automatic expRecT loadRecord(input int t);
		expRecT rec;
		int base;
		base = t * wordsPerTest;
		rec.testIdx = t;
		rec.instr = testMem[base];
		rec.exc = excT'(testMem[base+1][1:0]);
		rec.we = testMem[base+2][0];
		rec.dest = testMem[base+3][regAddrW-1:0];
		rec.data = testMem[base+4];
		return rec;
	endfunction

	// R-type with a given function code
	function automatic logic isRFunct(input instrWordT w, input logic [5:0] fn);
		return (w.rFields.op == rType) && (w.rFields.funct == fn);
	endfunction

	task automatic reportMismatch(input int idx, input string what,
		input logic [dataW-1:0] got, input logic [dataW-1:0] want);
		$display("error %0t: test %0d %s got %h expected %h", $time, idx, what, got, want);
	endtask

	// Compare one retire against the oldest outstanding record
	task automatic checkRetire();
		expRecT rec;
		logic ok;
		if (retire) begin
			assert (expQ.size() > 0) else begin
				$display("retire seen at time %0t with no instruction outstanding", $time);
				strayCount++;
			end
			if (expQ.size() > 0) begin
				rec = expQ.pop_front();
				ok = 1'b1;
				assert (retireExc == rec.exc) else begin
					reportMismatch(rec.testIdx, "retireExc", {30'b0, retireExc}, {30'b0, rec.exc});
					ok = 1'b0;
				end
				assert (retireWe == rec.we) else begin
					reportMismatch(rec.testIdx, "retireWe", {31'b0, retireWe}, {31'b0, rec.we});
					ok = 1'b0;
				end
				// Destination and data only mean something on a write
				if (rec.we) begin
					assert (retireDest == rec.dest) else begin
						reportMismatch(rec.testIdx, "retireDest", {27'b0, retireDest},
							{27'b0, rec.dest});
						ok = 1'b0;
					end
					assert (retireData == rec.data) else begin
						reportMismatch(rec.testIdx, "retireData", retireData, rec.data);
						ok = 1'b0;
					end
				end
				// mthi and mtlo rows carry the expected HI or LO
				if (rec.exc == excNone && isRFunct(rec.instr, mthiFn)) begin
					assert (hiOut == rec.data) else begin
						reportMismatch(rec.testIdx, "hiOut", hiOut, rec.data);
						ok = 1'b0;
					end
				end
				if (rec.exc == excNone && isRFunct(rec.instr, mtloFn)) begin
					assert (loOut == rec.data) else begin
						reportMismatch(rec.testIdx, "loOut", loOut, rec.data);
						ok = 1'b0;
					end
				end
				if (ok) begin
					passCount++;
				end else begin
					failCount++;
				end
				$display("test %0d instr %h %s", rec.testIdx, rec.instr, ok ? "ok" : "mismatch");
			end
		end
	endtask

	// Falling edge: check outputs, then drive
	task automatic stepCycle(input logic valid, input logic [dataW-1:0] word);
		@(negedge clk);
		checkRetire();
		instrValid = valid;
		instr = word;
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		integer r;
		int gap;
		expRecT rec;
		instrValid = 1'b0;
		instr = '0;
		seed = 32'h95c81061;
		testCount = 0;
		passCount = 0;
		failCount = 0;
		strayCount = 0;
		loaded = 1'b0;
		$readmemh("coreTests.mem", testMem);
		while (testCount < maxTests && testMem[testCount*wordsPerTest] != endMarker) begin
			testCount++;
		end
		loaded = 1'b1;
		@(posedge rstN);
		for (int t = 0; t < testCount; t++) begin
			// Idle gap of 0 to 2 cycles
			r = $random(seed);
			gap = (r & 32'h7fff_ffff) % 3;
			repeat (gap) stepCycle(1'b0, '0);
			rec = loadRecord(t);
			stepCycle(1'b1, rec.instr);
			expQ.push_back(rec);
		end
		// Drain, then a few cycles to catch stray retires
		while (expQ.size() > 0) begin
			stepCycle(1'b0, '0);
		end
		repeat (3) stepCycle(1'b0, '0);
		$display("tests %0d passed %0d failed %0d stray %0d", testCount, passCount, failCount,
			strayCount);
		if (failCount == 0 && strayCount == 0 && passCount == testCount) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog, budget grows with the test list
	initial begin
		wait (loaded);
		#((testCount * 4 + 20) * clkPeriod);
		$display("watchdog expired with %0d instructions not retired", expQ.size());
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

	import mipsIsaPkg::*;

	//////////////////////////////////////////////////
	// ALU operation
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpT;

	// Decoded control bundle
	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcImm;
		logic signExt;
		logic shiftByShamt;
		logic regWrite;
		logic regDstRd;
		logic hiloWrite;
		// HI/LO source, hiSel high means HI
		logic hiloToReg;
		logic hiSel;
		logic mulSigned;
		logic isMul;
	} ctrlT;

	// Exception codes reported at retire
	typedef enum logic [1:0] {
		excNone,
		excBrk,
		excSys,
		excResv
	} excT;

	//////////////////////////////////////////////////
	// Pipeline stage payloads
	//////////////////////////////////////////////////

	// Decode to execute
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		excT exc;
		logic [regAddrW-1:0] dest;
		logic [dataW-1:0] rsVal;
		logic [dataW-1:0] rtVal;
		logic [15:0] imm;
		logic [4:0] shamt;
	} exStageT;

	// Execute to result
	typedef struct packed {
		logic valid;
		excT exc;
		logic regWrite;
		logic [regAddrW-1:0] dest;
		logic [dataW-1:0] data;
	} wbStageT;

endpackage

`default_nettype wire

//--- mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	//////////////////////////////////////////////////
	// Register and data widths
	//////////////////////////////////////////////////

	localparam int dataW = 32;
	localparam int regAddrW = 5;
	localparam int regCount = 32;
	// Hardwired zero register
	localparam logic [regAddrW-1:0] zeroReg = 5'd0;

	//////////////////////////////////////////////////
	// Opcodes, bits 31:26
	//////////////////////////////////////////////////

	localparam logic [5:0] rType = 6'b000000;
	localparam logic [5:0] addiuOp = 6'b001001;
	localparam logic [5:0] sltiOp = 6'b001010;
	localparam logic [5:0] sltiuOp = 6'b001011;
	// Logical immediates, zero extended
	localparam logic [5:0] andiOp = 6'b001100;
	localparam logic [5:0] oriOp = 6'b001101;
	localparam logic [5:0] xoriOp = 6'b001110;
	localparam logic [5:0] luiOp = 6'b001111;

	//////////////////////////////////////////////////
	// Function codes for R-type, bits 5:0
	//////////////////////////////////////////////////

	// Shifts, constant then variable
	localparam logic [5:0] sllFn = 6'b000000;
	localparam logic [5:0] srlFn = 6'b000010;
	localparam logic [5:0] sraFn = 6'b000011;
	localparam logic [5:0] sllvFn = 6'b000100;
	localparam logic [5:0] srlvFn = 6'b000110;
	localparam logic [5:0] sravFn = 6'b000111;
	// Traps
	localparam logic [5:0] syscallFn = 6'b001100;
	localparam logic [5:0] breakFn = 6'b001101;
	// HI/LO moves, bit 1 picks LO
	localparam logic [5:0] mfhiFn = 6'b010000;
	localparam logic [5:0] mthiFn = 6'b010001;
	localparam logic [5:0] mfloFn = 6'b010010;
	localparam logic [5:0] mtloFn = 6'b010011;
	// Multiply, bit 0 marks unsigned
	localparam logic [5:0] multFn = 6'b011000;
	localparam logic [5:0] multuFn = 6'b011001;
	// Arithmetic and logic
	localparam logic [5:0] addFn = 6'b100000;
	localparam logic [5:0] adduFn = 6'b100001;
	localparam logic [5:0] subFn = 6'b100010;
	localparam logic [5:0] subuFn = 6'b100011;
	localparam logic [5:0] andFn = 6'b100100;
	localparam logic [5:0] orFn = 6'b100101;
	localparam logic [5:0] xorFn = 6'b100110;
	localparam logic [5:0] norFn = 6'b100111;
	localparam logic [5:0] sltFn = 6'b101010;
	localparam logic [5:0] sltuFn = 6'b101011;

	//////////////////////////////////////////////////
	// Instruction word, two views of one word
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFieldsT;

	typedef struct packed {
		logic [5:0] op;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [15:0] imm;
	} iFieldsT;

	typedef union packed {
		rFieldsT rFields;
		iFieldsT iFields;
	} instrWordT;

endpackage

`default_nettype wire

//--- regFileWriteback.sv
`default_nettype none

module regFileWriteback
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input wbStageT inStage,
	input wbStageT bypassEx,
	input logic [regAddrW-1:0] rsAddr,
	input logic [regAddrW-1:0] rtAddr,
	output logic [dataW-1:0] rsData,
	output logic [dataW-1:0] rtData,
	output logic retire,
	output excT retireExc,
	output logic retireWe,
	output logic [regAddrW-1:0] retireDest,
	output logic [dataW-1:0] retireData
);

	wbStageT wbReg;
	wbStageT retReg;
	logic [dataW-1:0] regs [regCount];

	//////////////////////////////////////////////////
	// Result and retire registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbReg <= '0;
			retReg <= '0;
		end else begin
			wbReg <= inStage;
			// Report in the same cycle the array takes the write
			retReg <= wbReg;
		end
	end

	// Register file, all zero out of reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbReg.regWrite) begin
			regs[wbReg.dest] <= wbReg.data;
		end
	end

	//////////////////////////////////////////////////
	// Bypassed operand reads
	//////////////////////////////////////////////////

	// Youngest writer first, then array
	function automatic logic [dataW-1:0] readOperand(input logic [regAddrW-1:0] addr);
		if (addr == zeroReg) begin
			return '0;
		end else if (bypassEx.regWrite && (bypassEx.dest == addr)) begin
			return bypassEx.data;
		end else if (wbReg.regWrite && (wbReg.dest == addr)) begin
			return wbReg.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readOperand(rsAddr);
		rtData = readOperand(rtAddr);
	end

	// Retire port
	assign retire = retReg.valid;
	assign retireExc = retReg.exc;
	assign retireWe = retReg.regWrite;
	assign retireDest = retReg.dest;
	assign retireData = retReg.data;

	// Trap seen at decode retires with no write
	retireExcNoWe: assert property (@(posedge clk) disable iff (!rstN)
		retire && (retireExc != excNone) |-> !retireWe);

endmodule

`default_nettype wire

//--- tb.f
mipsIsaPkg.sv
mipsCtrlPkg.sv
mainDecoder.sv
aluExecute.sv
regFileWriteback.sv
mipsCore.sv
tbClock.sv
mipsCoreTb.sv

//--- tbClock.sv
`default_nettype none

module tbClock (
	output logic clk,
	output logic rstN
);

	// Free running clock, period of 4
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset low for three cycles, released away from the rising edge
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire
